// ==== source/spinn_link_pkg.sv ====
/*
  shared widths, typedefs and flit/packet structs of the link receiver,
  2-of-7 code table with data detect and decode functions
*/
`default_nettype none

package spinn_link_pkg;

  localparam int PKT_BITS    = 72;  // long packet, 18 nibbles
  localparam int SYM_BITS    = 7;   // one wire per bit
  localparam int NIBBLE_BITS = 4;

  typedef logic [SYM_BITS-1:0]    sym_t;
  typedef logic [NIBBLE_BITS-1:0] nibble_t;
  typedef logic [4:0]             flit_cnt_t;
  typedef logic [PKT_BITS-1:0]    pkt_t;

  localparam flit_cnt_t SHORT_FLITS = 5'd10;
  localparam flit_cnt_t LONG_FLITS  = 5'd18;
  localparam int        LEN_BIT     = 1;            // long flag in header flit
  localparam sym_t      EOP_SYM     = 7'b1100000;   // wires 6 and 5

  // rtz codes for data values 0..15
  localparam sym_t SYM_TABLE [16] = '{
    7'b0010001, 7'b0010010, 7'b0010100, 7'b0011000,
    7'b0100001, 7'b0100010, 7'b0100100, 7'b0101000,
    7'b1000001, 7'b1000010, 7'b1000100, 7'b1001000,
    7'b0000011, 7'b0000110, 7'b0001100, 7'b0001001
  };

  // flit strobes, receiver to assembler
  typedef struct packed {
    logic    dat;   // data flit strobe
    logic    eop;   // end-of-packet strobe
    nibble_t data;  // decoded value, valid with dat
  } flit_t;

  // finished packet, assembler to output stage
  typedef struct packed {
    logic done;      // eop seen this cycle
    logic frame_ok;  // flit count matched length
    logic long_pkt;
    pkt_t pkt;
  } pkt_done_t;

  // rtz code is one of the 16 data codes
  function automatic logic sym_is_data(sym_t s);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 16; i++) begin
      if (s == SYM_TABLE[i]) hit = 1'b1;
    end
    return hit;
  endfunction

  // rtz code to nibble, zero when not a data code
  function automatic nibble_t sym_decode(sym_t s);
    nibble_t val;
    val = '0;
    for (int i = 0; i < 16; i++) begin
      if (s == SYM_TABLE[i]) val = nibble_t'(i);
    end
    return val;
  endfunction

endpackage

`default_nettype wire

// ==== source/flit_receiver.sv ====
/*
  link input synchroniser, nrz to rtz conversion, 2-of-7 symbol decode
  and header-paced acknowledge state machine
*/
`default_nettype none

module flit_receiver #(
  parameter int SYNC_STAGES     = 2,
  parameter int INTER_ACK_DELAY = 1
) (
  input  wire                          CLK_IN,
  input  wire                          RESET_IN,
  input  wire spinn_link_pkg::sym_t    link_data,
  input  wire                          cts,
  output logic                         link_ack,
  output spinn_link_pkg::flit_t        flit
);

  localparam int DLY_W = (INTER_ACK_DELAY > 0) ? $clog2(INTER_ACK_DELAY + 1) : 1;
  localparam logic [DLY_W-1:0] DLY_LOAD = DLY_W'(INTER_ACK_DELAY);

  typedef enum logic [1:0] {
    ST_START,  // ack once on reset exit
    ST_IDLE,   // wait for header flit
    ST_RECV,   // paced pre-acks for the rest
    ST_EOPW    // eop seen, wait for cts
  } rx_state_t;

  spinn_link_pkg::sym_t      sync_q [SYNC_STAGES];  // synchroniser chain
  spinn_link_pkg::sym_t      old_q;     // last accepted line state
  spinn_link_pkg::sym_t      rtz;       // wires that changed
  spinn_link_pkg::nibble_t   new_data;
  logic                      dat_sym;
  logic                      eop_sym;
  logic                      accept;    // symbol taken this cycle
  logic                      send_ack;
  spinn_link_pkg::flit_cnt_t ack_cnt;   // acks sent for this packet
  spinn_link_pkg::flit_cnt_t ack_tot;   // acks owed by the header
  logic [DLY_W-1:0]          dly_cnt;   // inter-ack spacing
  rx_state_t                 state;
  logic                      flit_dat_q;
  logic                      flit_eop_q;
  spinn_link_pkg::nibble_t   flit_data_q;

  // --------------------------------------------------------------------------
  // synchroniser and symbol decode
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN) begin
    sync_q[0] <= link_data;
    for (int i = 1; i < SYNC_STAGES; i++) begin
      sync_q[i] <= sync_q[i-1];
    end
  end

  always_comb begin
    rtz      = sync_q[SYNC_STAGES-1] ^ old_q;  // nrz -> rtz
    dat_sym  = spinn_link_pkg::sym_is_data(rtz);
    eop_sym  = (rtz == spinn_link_pkg::EOP_SYM);
    new_data = spinn_link_pkg::sym_decode(rtz);
    // only idle/recv take symbols, and only with cts
    accept   = cts && (dat_sym || eop_sym) && (state == ST_IDLE || state == ST_RECV);
  end

  // line state follows the wires during start, then per accepted symbol
  always_ff @(posedge CLK_IN) begin
    if (state == ST_START || accept) begin
      old_q <= sync_q[SYNC_STAGES-1];
    end
  end

  // --------------------------------------------------------------------------
  // acknowledge generation
  // --------------------------------------------------------------------------
  always_comb begin
    case (state)
      ST_START: send_ack = 1'b1;      // start ack
      ST_IDLE:  send_ack = accept;    // header flit
      ST_RECV:  send_ack = ((dly_cnt == '0) && (ack_cnt < ack_tot)) || (accept && eop_sym);
      default:  send_ack = 1'b0;
    endcase
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      link_ack <= 1'b0;
    end else if (send_ack) begin
      link_ack <= ~link_ack;
    end
  end

  // header decides how many flits to pre-ack
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_tot <= spinn_link_pkg::SHORT_FLITS;
    end else if (state == ST_IDLE && accept && dat_sym) begin
      ack_tot <= new_data[spinn_link_pkg::LEN_BIT] ? spinn_link_pkg::LONG_FLITS
                                                   : spinn_link_pkg::SHORT_FLITS;
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_cnt <= '0;
    end else if (state == ST_START || state == ST_EOPW) begin
      ack_cnt <= '0;
    end else if (send_ack) begin
      ack_cnt <= ack_cnt + 1'b1;
    end
  end

  // free-running reload in recv, acks only on zero
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      dly_cnt <= DLY_LOAD;
    end else if (state != ST_RECV || dly_cnt == '0) begin
      dly_cnt <= DLY_LOAD;
    end else begin
      dly_cnt <= dly_cnt - 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // state machine
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= ST_START;
    end else begin
      case (state)
        ST_START: state <= ST_IDLE;
        ST_IDLE: begin
          if (accept) begin
            state <= eop_sym ? ST_EOPW : ST_RECV;  // stray eop skips recv
          end
        end
        ST_RECV: begin
          if (accept && eop_sym) begin
            state <= ST_EOPW;
          end
        end
        default: begin
          if (cts) begin
            state <= ST_IDLE;  // output stage ready again
          end
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // flit strobes, one cycle after acceptance
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_dat_q <= 1'b0;
      flit_eop_q <= 1'b0;
    end else begin
      flit_dat_q <= accept && dat_sym;
      flit_eop_q <= accept && eop_sym;
    end
  end

  always_ff @(posedge CLK_IN) begin
    if (accept && dat_sym) begin
      flit_data_q <= new_data;
    end
  end

  assign flit = '{dat: flit_dat_q, eop: flit_eop_q, data: flit_data_q};

endmodule

`default_nettype wire

// ==== source/pkt_assembler.sv ====
/*
  packet assembly from data flits, flit counting,
  length flag and end-of-packet framing check
*/
`default_nettype none

module pkt_assembler (
  input  wire                            CLK_IN,
  input  wire                            RESET_IN,
  input  wire spinn_link_pkg::flit_t     flit,
  output spinn_link_pkg::pkt_done_t      done
);

  // short packet sits in the top 40 bits of the buffer
  localparam int SHORT_SHIFT = spinn_link_pkg::PKT_BITS
                               - spinn_link_pkg::NIBBLE_BITS * spinn_link_pkg::SHORT_FLITS;
  localparam spinn_link_pkg::flit_cnt_t CNT_MAX = '1;

  spinn_link_pkg::pkt_t      pkt_buf;   // nibbles enter at the top
  spinn_link_pkg::flit_cnt_t cnt_q;     // data flits in current packet
  spinn_link_pkg::flit_cnt_t exp_cnt;   // count the eop should see
  logic                      long_q;    // header length flag
  logic                      first;     // next data flit is the header
  logic                      frame_ok;

  assign first = (cnt_q == '0);

  // --------------------------------------------------------------------------
  // flit shift buffer
  // --------------------------------------------------------------------------
  // flit k ends at bits 4k+3:4k after 18 shifts
  always_ff @(posedge CLK_IN) begin
    if (flit.dat) begin
      pkt_buf <= {flit.data,
                  pkt_buf[spinn_link_pkg::PKT_BITS-1:spinn_link_pkg::NIBBLE_BITS]};
    end
  end

  // --------------------------------------------------------------------------
  // flit count and length flag
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      cnt_q <= '0;
    end else if (flit.eop) begin
      cnt_q <= '0;  // ready for next header
    end else if (flit.dat && cnt_q != CNT_MAX) begin
      cnt_q <= cnt_q + 1'b1;  // saturate on runaway packets
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      long_q <= 1'b0;
    end else if (flit.dat && first) begin
      long_q <= flit.data[spinn_link_pkg::LEN_BIT];
    end
  end

  // --------------------------------------------------------------------------
  // framing check and result
  // --------------------------------------------------------------------------
  // all from registered state, valid in the eop strobe cycle
  always_comb begin
    exp_cnt  = long_q ? spinn_link_pkg::LONG_FLITS : spinn_link_pkg::SHORT_FLITS;
    frame_ok = (cnt_q == exp_cnt);

    done.done     = flit.eop;
    done.frame_ok = flit.eop && frame_ok;
    done.long_pkt = long_q;
    if (long_q) begin
      done.pkt = pkt_buf;
    end else begin
      done.pkt = pkt_buf >> SHORT_SHIFT;  // upper bits fill with zero
    end
  end

endmodule

`default_nettype wire

// ==== source/pkt_output.sv ====
/*
  packet output register with valid/ready handshake,
  pending-packet wait with clear-to-send, framing error pulse
*/
`default_nettype none

module pkt_output (
  input  wire                            CLK_IN,
  input  wire                            RESET_IN,
  input  wire spinn_link_pkg::pkt_done_t done,
  input  wire                            pkt_rdy,
  output logic                           cts,
  output spinn_link_pkg::pkt_t           pkt_data,
  output logic                           pkt_vld,
  output logic                           frm_err
);

  typedef enum logic {
    OUT_RUN,   // output free or draining normally
    OUT_WAIT   // assembled packet held back
  } out_state_t;

  out_state_t state;
  logic       busy;  // held packet not yet taken
  logic       good;  // well-framed packet this cycle
  logic       load;  // output register takes a packet

  always_comb begin
    busy = pkt_vld && !pkt_rdy;
    good = done.done && done.frame_ok;
    // in wait the assembler buffer still holds the pending packet
    load = !busy && (good || state == OUT_WAIT);
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state   <= OUT_RUN;
      cts     <= 1'b0;
      pkt_vld <= 1'b0;
      frm_err <= 1'b0;
    end else begin
      frm_err <= done.done && !done.frame_ok;  // bad packets dropped here
      if (!busy) begin
        pkt_vld <= load;
      end
      case (state)
        OUT_RUN: begin
          if (good && busy) begin
            state <= OUT_WAIT;
            cts   <= 1'b0;  // stall the link
          end else begin
            cts   <= 1'b1;
          end
        end
        default: begin
          if (!busy) begin
            state <= OUT_RUN;
            cts   <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK_IN) begin
    if (load) begin
      pkt_data <= done.pkt;
    end
  end

endmodule

`default_nettype wire

// ==== source/spinn_link_rx.sv ====
/*
  spinnaker link receiver top level
  flit receiver, packet assembler and output stage in a chain
*/
`default_nettype none

module spinn_link_rx #(
  parameter int SYNC_STAGES     = 2,  // input synchroniser depth
  parameter int INTER_ACK_DELAY = 1   // idle cycles between acks
) (
  input  wire                         CLK_IN,
  input  wire                         RESET_IN,
  // link side
  input  wire spinn_link_pkg::sym_t   link_data,  // async nrz wires
  output wire                         link_ack,   // toggle per ack
  // packet side
  output wire spinn_link_pkg::pkt_t   pkt_data,
  output wire                         pkt_vld,
  input  wire                         pkt_rdy,
  // error report
  output wire                         frm_err     // one-cycle pulse
);

  // --------------------------------------------------------------------------
  // internal links
  // --------------------------------------------------------------------------
  spinn_link_pkg::flit_t     flit;  // dat/eop strobes + nibble
  spinn_link_pkg::pkt_done_t done;  // finished packet strobe
  logic                      cts;   // receiver may accept symbols

  flit_receiver #(
    .SYNC_STAGES     (SYNC_STAGES),
    .INTER_ACK_DELAY (INTER_ACK_DELAY)
  ) i_flit_receiver (
    .CLK_IN    (CLK_IN),
    .RESET_IN  (RESET_IN),
    .link_data (link_data),
    .cts       (cts),
    .link_ack  (link_ack),
    .flit      (flit)
  );

  pkt_assembler i_pkt_assembler (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .flit     (flit),
    .done     (done)
  );

  pkt_output i_pkt_output (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .done     (done),
    .pkt_rdy  (pkt_rdy),
    .cts      (cts),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .frm_err  (frm_err)
  );

endmodule

`default_nettype wire

// ==== verification/spinn_link_rx_asserts.sv ====
/*
  concurrent checks on the packet handshake, frm_err pulse width
  and flit strobes, bound into the receiver top level
*/
`default_nettype none

module spinn_link_rx_asserts (
  input wire                        CLK_IN,
  input wire                        RESET_IN,
  input wire spinn_link_pkg::pkt_t  pkt_data,
  input wire                        pkt_vld,
  input wire                        pkt_rdy,
  input wire                        frm_err,
  input wire spinn_link_pkg::flit_t flit
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;  // failed checks so far

  // stalled packet holds still
  hold_while_stalled: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (pkt_vld && !pkt_rdy) |=> (pkt_vld && $stable(pkt_data)))
    else begin
      fail_cnt++;
      $error("pkt_vld dropped or pkt_data changed while stalled");
    end

  frm_err_pulse: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    frm_err |=> !frm_err)
    else begin
      fail_cnt++;
      $error("frm_err high for two cycles in a row");
    end

  // dat and eop strobes exclusive
  flit_strobes: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    !(flit.dat && flit.eop))
    else begin
      fail_cnt++;
      $error("flit dat and eop strobes high together");
    end

endmodule

bind spinn_link_rx spinn_link_rx_asserts i_spinn_link_rx_asserts (
  .CLK_IN   (CLK_IN),
  .RESET_IN (RESET_IN),
  .pkt_data (pkt_data),
  .pkt_vld  (pkt_vld),
  .pkt_rdy  (pkt_rdy),
  .frm_err  (frm_err),
  .flit     (flit)
);

`default_nettype wire

// ==== verification/tb_spinn_link_rx.sv ====
/*
  testbench of the link receiver: clock and reset, 2-of-7 link transmitter
  model, packet scoreboard, directed tests and watchdog
*/
`default_nettype none

module tb_spinn_link_rx;
  timeunit 1ns;
  timeprecision 1ps;

  typedef spinn_link_pkg::pkt_t pkt_t;
  typedef spinn_link_pkg::sym_t sym_t;

  localparam int CLK_PERIOD   = 40;
  localparam int SYNC_STAGES  = 2;
  localparam int ACK_DELAY    = 1;
  localparam int SYM_GAP      = SYNC_STAGES + 2;  // lets each symbol get taken
  localparam int STALL_CYCLES = 40;
  // symbols incl. eop per test, mixed stream counted as all long
  localparam int TOTAL_SYMS   = 11 + 19 + 41 + 8 * 19 + 18;
  localparam int WDOG_CYCLES  = TOTAL_SYMS * 20 + STALL_CYCLES + 200;
  localparam pkt_t SHORT_MASK = {32'h0, {40{1'b1}}};

  logic       clk;
  logic       reset;
  sym_t       link_data;  // nrz line state of the transmitter
  logic       link_ack;
  pkt_t       pkt_data;
  logic       pkt_vld;
  logic       pkt_rdy;
  logic       frm_err;
  int         seed = 32'hf625;
  pkt_t       exp_q [$];  // scoreboard, in send order
  pkt_t       exp_pkt;
  logic [2:0] ack_pipe;   // transmitter side ack synchroniser
  int         acks_seen;
  int         syms_sent;
  int         pkts_sent;
  int         xfer_cnt;
  int         err_cnt;

  spinn_link_rx #(
    .SYNC_STAGES     (SYNC_STAGES),
    .INTER_ACK_DELAY (ACK_DELAY)
  ) i_spinn_link_rx (
    .CLK_IN    (clk),
    .RESET_IN  (reset),
    .link_data (link_data),
    .link_ack  (link_ack),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .frm_err   (frm_err)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // reporting
  // --------------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_equal(input string what, input pkt_t got, input pkt_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
      abort_run("value check failed");
    end
  endtask

  // --------------------------------------------------------------------------
  // link transmitter model
  // --------------------------------------------------------------------------
  // every ack toggle seen past the sync is one symbol credit
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      ack_pipe  <= '0;
      acks_seen <= 0;
    end else begin
      ack_pipe <= {ack_pipe[1:0], link_ack};
      if (ack_pipe[2] != ack_pipe[1]) acks_seen <= acks_seen + 1;
    end
  end

  task automatic send_symbol(input sym_t code);
    @(negedge clk);
    while (acks_seen <= syms_sent) @(negedge clk);  // no credit yet
    link_data = link_data ^ code;  // toggle two wires
    syms_sent++;
    repeat (SYM_GAP) @(negedge clk);
  endtask

  // flit k from bits 4k+3:4k, lowest first
  task automatic send_packet(input pkt_t p, input int nflits);
    for (int k = 0; k < nflits; k++) begin
      send_symbol(spinn_link_pkg::SYM_TABLE[p[4*k +: 4]]);
    end
    send_symbol(spinn_link_pkg::EOP_SYM);
    pkts_sent++;
  endtask

  function automatic int flits_in(input pkt_t p);
    return p[spinn_link_pkg::LEN_BIT] ? spinn_link_pkg::LONG_FLITS
                                      : spinn_link_pkg::SHORT_FLITS;
  endfunction

  function automatic pkt_t random_packet(input logic is_long);
    pkt_t p;
    p = pkt_t'({$random(seed), $random(seed), $random(seed)});
    if (!is_long) p = p & SHORT_MASK;  // short packets are 40 bits
    p[spinn_link_pkg::LEN_BIT] = is_long;
    return p;
  endfunction

  // --------------------------------------------------------------------------
  // scoreboard and monitors
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (!reset && pkt_vld && pkt_rdy) begin
      if (exp_q.size() == 0) begin
        abort_run("packet transferred while none was expected");
      end else begin
        exp_pkt = exp_q.pop_front();
        check_equal("packet", pkt_data, exp_pkt);
        xfer_cnt++;
      end
    end
  end

  always @(posedge clk or posedge reset) begin
    if (reset) err_cnt <= 0;
    else if (frm_err) err_cnt <= err_cnt + 1;
  end

  always @(negedge clk) begin
    if (i_spinn_link_rx.i_spinn_link_rx_asserts.fail_cnt != 0) begin
      abort_run("a bound assertion in the receiver failed");
    end
  end

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    abort_run("watchdog timeout, the tests did not complete in time");
  end

  task automatic wait_drained();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (6) @(negedge clk);  // room for a stray transfer or error
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic single_packet_test(input logic is_long);
    pkt_t p;
    int   errs;
    p     = random_packet(is_long);
    errs  = err_cnt;
    exp_q.push_back(p);
    send_packet(p, flits_in(p));
    wait_drained();
    check_equal("frm_err pulses", pkt_t'(err_cnt), pkt_t'(errs));
  endtask

  task automatic backpressure_test();
    pkt_t p [3];
    int   xfers;
    int   base;
    p[0]  = random_packet(1'b0);
    p[1]  = random_packet(1'b1);
    p[2]  = random_packet(1'b0);
    xfers = xfer_cnt;
    base  = pkts_sent;
    pkt_rdy = 1'b0;
    for (int i = 0; i < 3; i++) exp_q.push_back(p[i]);
    fork
      for (int i = 0; i < 3; i++) send_packet(p[i], flits_in(p[i]));
      begin
        while (pkts_sent < base + 2) @(negedge clk);
        repeat (STALL_CYCLES) @(negedge clk);  // third header now stuck
        check_equal("pkt_vld while stalled", pkt_t'(pkt_vld), pkt_t'(1));
        check_equal("transfers while stalled", pkt_t'(xfer_cnt), pkt_t'(xfers));
        pkt_rdy = 1'b1;
      end
    join
    wait_drained();
  endtask

  task automatic mixed_stream_test();
    pkt_t p [8];
    logic sending;
    for (int i = 0; i < 8; i++) begin
      p[i] = random_packet(($random(seed) & 32'd1) != 0);
      exp_q.push_back(p[i]);
    end
    sending = 1'b1;
    fork
      begin
        for (int i = 0; i < 8; i++) send_packet(p[i], flits_in(p[i]));
        sending = 1'b0;
      end
      begin
        while (sending) begin
          @(negedge clk);
          pkt_rdy = ($random(seed) & 32'd1) != 0;
        end
        pkt_rdy = 1'b1;
      end
    join
    wait_drained();
  endtask

  // six flits under a short header, then one good packet
  task automatic framing_error_test();
    pkt_t bad;
    pkt_t p;
    int   errs;
    bad   = random_packet(1'b0);
    p     = random_packet(1'b0);
    errs  = err_cnt;
    send_packet(bad, 6);
    while (err_cnt == errs) @(negedge clk);
    exp_q.push_back(p);
    send_packet(p, flits_in(p));
    wait_drained();
    check_equal("frm_err pulses", pkt_t'(err_cnt), pkt_t'(errs + 1));
  endtask

  initial begin
    reset     = 1'b1;
    link_data = '0;
    pkt_rdy   = 1'b0;
    syms_sent = 0;
    pkts_sent = 0;
    xfer_cnt  = 0;
    repeat (2) @(negedge clk);
    check_equal("link_ack in reset", pkt_t'(link_ack), pkt_t'(0));
    check_equal("pkt_vld in reset", pkt_t'(pkt_vld), pkt_t'(0));
    check_equal("frm_err in reset", pkt_t'(frm_err), pkt_t'(0));
    reset   = 1'b0;
    pkt_rdy = 1'b1;
    @(negedge clk);
    check_equal("start ack", pkt_t'(link_ack), pkt_t'(1));  // first cycle out of reset
    single_packet_test(1'b0);
    single_packet_test(1'b1);
    backpressure_test();
    mixed_stream_test();
    framing_error_test();  // leaves spare link credits, so it runs last
    if (err_cnt == 1) begin
      $display("TEST OK");
      $finish;
    end else begin
      abort_run("wrong frm_err count at end of run");
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
source/spinn_link_pkg.sv
source/flit_receiver.sv
source/pkt_assembler.sv
source/pkt_output.sv
source/spinn_link_rx.sv
verification/spinn_link_rx_asserts.sv
verification/tb_spinn_link_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the link receiver testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_spinn_link_rx

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_spinn_link_rx -f all.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"$BIN" +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
echo "simulation passed"
exit 0
